// File: list.f
+incdir+hw
hw/mem_bus_pkg.sv
hw/req_track_pkg.sv
hw/data_port_merge.sv
hw/mem_port_arbiter.sv
hw/vmem_subsys_top.sv
verif/tb_vmem_subsys.sv

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the memory subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1
log=sim.log

verilator --binary --timing --assert -Wno-fatal -f list.f \
    --top-module tb_vmem_subsys -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_vmem_subsys > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qx "TB PASSED" "$log"; then
    exit 0
fi
echo "pass message not found in $log"
exit 1

// File: verif/tb_vmem_subsys.sv
/*
 * memory subsystem testbench: in-order memory model, directed and
 * random stimulus, reference function and response checker
 */
`timescale 1ns/10ps
`include "mem_consts.svh"

module tb_vmem_subsys import mem_bus_pkg::*; ();

    localparam int NB      = `DATA_W / 8;
    localparam int TIMEOUT = 200;

    typedef enum {I_GRANT, I_RVALID, S_GRANT, S_RVALID, V_GRANT, V_RVALID} wait_e;

    logic               clk_i, rst_ni;
    logic               ireq_i, igrant_o, irvalid_o;
    logic [`ADDR_W-1:0] iaddr_i;
    word_rsp_t          irsp_o;
    logic               sreq_i, sgnt_o, srvalid_o;
    word_req_t          sreq_data_i;
    word_rsp_t          srsp_o;
    logic               vreq_i, vgnt_o, vrvalid_o;
    wide_req_t          vreq_data_i;
    wide_rsp_t          vrsp_o;
    logic               vpend_load_i, vpend_store_i;
    logic               mem_req_o, mem_rvalid_i;
    wide_req_t          mem_req_data_o;
    wide_rsp_t          mem_rsp_i;

    logic [31:0] lfsr_q = 32'h9ccb0973;
    logic [7:0]  img [logic [31:0]];        // expected memory image
    logic [7:0]  mem_bytes [logic [31:0]];  // memory model store
    logic [33:0] iexp_q [$], sexp_q [$];    // err, then a flag set when rdata is compared
    logic [65:0] vexp_q [$];

    vmem_subsys_top dut_i (.*);

    always #20 clk_i = ~clk_i;

    // fibonacci lfsr, taps 32 22 2 1
    function automatic logic [31:0] rand_bits(int unsigned n);
        logic [31:0] r;
        r = '0;
        for (int unsigned i = 0; i < n; i++) begin
            r = {r[30:0], lfsr_q[31]};
            lfsr_q = {lfsr_q[30:0], lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0]};
        end
        return r;
    endfunction

    function automatic logic [7:0] fill_byte(logic [31:0] a);
        return (a[7:0] * 8'd13) ^ a[15:8] ^ a[23:16] ^ a[31:24];
    endfunction

    // every eighth line answers with a bus error
    function automatic logic err_line(logic [31:0] a);
        return a[5:3] == 3'b111;
    endfunction

    // expected line: written bytes, else the fill pattern
    function automatic logic [`DATA_W-1:0] ref_line(logic [31:0] addr);
        logic [`DATA_W-1:0] line;
        logic [31:0]        a;
        for (int i = 0; i < NB; i++) begin
            a = {addr[31:3], 3'b000} + i;
            line[i*8 +: 8] = img.exists(a) ? img[a] : fill_byte(a);
        end
        return line;
    endfunction

    function automatic logic [31:0] ref_word(logic [31:0] addr);
        logic [`DATA_W-1:0] line;
        line = ref_line(addr);
        return line[addr[2]*32 +: 32];
    endfunction

    function automatic void store(logic [31:0] addr, logic [NB-1:0] be, logic [`DATA_W-1:0] d);
        for (int i = 0; i < NB; i++) begin
            if (be[i]) img[{addr[31:3], 3'b000} + i] = d[i*8 +: 8];
        end
    endfunction

    function automatic wide_rsp_t mem_access(wide_req_t r);
        wide_rsp_t   rsp;
        logic [31:0] a;
        rsp = '0;
        for (int i = 0; i < NB; i++) begin
            a = {r.addr[31:3], 3'b000} + i;
            if (r.we && r.be[i]) mem_bytes[a] = r.wdata[i*8 +: 8];
            if (!r.we) rsp.rdata[i*8 +: 8] = mem_bytes.exists(a) ? mem_bytes[a] : fill_byte(a);
        end
        rsp.err = err_line(r.addr);
        return rsp;
    endfunction

    function automatic logic sampled(wait_e w);
        case (w)
            I_GRANT:  return igrant_o;
            I_RVALID: return irvalid_o;
            S_GRANT:  return sgnt_o;
            S_RVALID: return srvalid_o;
            V_GRANT:  return vgnt_o;
            default:  return vrvalid_o;
        endcase
    endfunction

    task automatic fail(string reason);
        $display("%s", reason);
        $display("TB FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check(string name, logic [63:0] got, logic [63:0] exp);
        if (got !== exp) begin
            fail($sformatf("CHECK FAILED %s: got 0x%0h expected 0x%0h", name, got, exp));
        end
    endtask

    task automatic wait_for(wait_e w);
        int n;
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
            if (n > TIMEOUT) fail($sformatf("timed out waiting for %s", w.name()));
        end while (!sampled(w));
    endtask

    task automatic drain();
        int n;
        n = 0;
        do begin
            @(posedge clk_i);
            n++;
            if (n > TIMEOUT) fail("timed out with responses still outstanding");
        end while (iexp_q.size() + sexp_q.size() + vexp_q.size() != 0);
    endtask

    task automatic expect_no_sgnt(int unsigned cycles);
        repeat (cycles) begin
            @(posedge clk_i);
            check("sgnt_o", 64'(sgnt_o), 64'(0));
        end
    endtask

    task automatic fetch(logic [31:0] a);
        iaddr_i <= a;
        ireq_i  <= 1'b1;
        wait_for(I_GRANT);
        ireq_i <= 1'b0;
        wait_for(I_RVALID);
    endtask

    task automatic scalar_start(logic we, logic [31:0] a, logic [3:0] be, logic [31:0] d);
        sreq_i      <= 1'b1;
        sreq_data_i <= '{addr: a, we: we, be: be, wdata: d};
    endtask

    task automatic scalar_finish();
        wait_for(S_GRANT);
        sreq_i <= 1'b0;
        wait_for(S_RVALID);
    endtask

    task automatic vector_start(logic we, logic [31:0] a, logic [NB-1:0] be, logic [63:0] d);
        vreq_i      <= 1'b1;
        vreq_data_i <= '{addr: a, we: we, be: be, wdata: d};
    endtask

    task automatic vector_finish();
        wait_for(V_GRANT);
        vreq_i <= 1'b0;
        wait_for(V_RVALID);
    endtask

    ////////////////////
    // memory model

    initial begin : mem_model
        int unsigned cyc, due;
        int unsigned due_q [$];
        wide_rsp_t   rsp_q [$];
        cyc          = 0;
        mem_rvalid_i = 1'b0;
        mem_rsp_i    = '0;
        forever begin
            @(posedge clk_i);
            cyc++;
            if (due_q.size() != 0 && due_q[0] == cyc) begin
                mem_rvalid_i <= 1'b1;
                mem_rsp_i    <= rsp_q.pop_front();
                void'(due_q.pop_front());
            end else begin
                mem_rvalid_i <= 1'b0;
            end
            if (rst_ni && mem_req_o) begin
                due = cyc + 1 + rand_bits(2);  // 1 to 4 cycles, kept in order
                if (due_q.size() != 0 && due <= due_q[$]) due = due_q[$] + 1;
                due_q.push_back(due);
                rsp_q.push_back(mem_access(mem_req_data_o));
            end
        end
    end

    ////////////////////
    // checker

    always @(posedge clk_i) begin : compare
        logic [NB-1:0]      sbe;
        logic [`DATA_W-1:0] sdat;
        logic [33:0]        we_exp;
        logic [65:0]        wv_exp;
        if (rst_ni) begin
            if (ireq_i && igrant_o) begin
                iexp_q.push_back({err_line(iaddr_i), 1'b1, ref_word(iaddr_i)});
            end
            if (sreq_i && sgnt_o) begin
                sbe  = sreq_data_i.addr[2] ? {sreq_data_i.be, 4'h0} : {4'h0, sreq_data_i.be};
                sdat = {2{sreq_data_i.wdata}};
                check("mem_req_data_o.addr", 64'(mem_req_data_o.addr), 64'(sreq_data_i.addr));
                if (sreq_data_i.we) begin
                    check("mem_req_data_o.be", 64'(mem_req_data_o.be), 64'(sbe));
                    check("mem_req_data_o.wdata", mem_req_data_o.wdata, sdat);
                    store(sreq_data_i.addr, sbe, sdat);
                    sexp_q.push_back({err_line(sreq_data_i.addr), 33'h0});
                end else begin
                    sexp_q.push_back({err_line(sreq_data_i.addr), 1'b1,
                                      ref_word(sreq_data_i.addr)});
                end
            end
            if (vreq_i && vgnt_o) begin
                if (vreq_data_i.we) begin
                    store(vreq_data_i.addr, vreq_data_i.be, vreq_data_i.wdata);
                    vexp_q.push_back({err_line(vreq_data_i.addr), 65'h0});
                end else begin
                    vexp_q.push_back({err_line(vreq_data_i.addr), 1'b1,
                                      ref_line(vreq_data_i.addr)});
                end
            end
            if (irvalid_o) begin
                if (iexp_q.size() == 0) fail("instruction response without a granted fetch");
                we_exp = iexp_q.pop_front();
                check("irsp_o.err", 64'(irsp_o.err), 64'(we_exp[33]));
                check("irsp_o.rdata", 64'(irsp_o.rdata), 64'(we_exp[31:0]));
            end
            if (srvalid_o) begin
                if (sexp_q.size() == 0) fail("scalar response without a granted request");
                we_exp = sexp_q.pop_front();
                check("srsp_o.err", 64'(srsp_o.err), 64'(we_exp[33]));
                if (we_exp[32]) check("srsp_o.rdata", 64'(srsp_o.rdata), 64'(we_exp[31:0]));
            end
            if (vrvalid_o) begin
                if (vexp_q.size() == 0) fail("vector response without a granted request");
                wv_exp = vexp_q.pop_front();
                check("vrsp_o.err", 64'(vrsp_o.err), 64'(wv_exp[65]));
                if (wv_exp[64]) check("vrsp_o.rdata", vrsp_o.rdata, wv_exp[63:0]);
            end
        end
    end

    ////////////////////
    // stimulus

    task automatic random_fetch(int unsigned n);
        repeat (n) begin
            repeat (rand_bits(2)) @(posedge clk_i);
            fetch(32'h4000 + (rand_bits(6) << 2));
        end
    endtask

    task automatic random_scalar(int unsigned n);
        repeat (n) begin
            repeat (rand_bits(2)) @(posedge clk_i);
            scalar_start(rand_bits(1), 32'h4000 + (rand_bits(6) << 2), rand_bits(4), rand_bits(32));
            scalar_finish();
        end
    endtask

    task automatic random_vector(int unsigned n);
        repeat (n) begin
            repeat (rand_bits(2)) @(posedge clk_i);
            vector_start(rand_bits(1), 32'h4000 + (rand_bits(5) << 3), rand_bits(8),
                         {rand_bits(32), rand_bits(32)});
            vector_finish();
        end
    endtask

    initial begin : stimulus
        clk_i         = 1'b0;
        rst_ni        = 1'b0;
        ireq_i        = 1'b0;
        iaddr_i       = '0;
        sreq_i        = 1'b0;
        sreq_data_i   = '0;
        vreq_i        = 1'b0;
        vreq_data_i   = '0;
        vpend_load_i  = 1'b0;
        vpend_store_i = 1'b0;
        repeat (3) @(posedge clk_i);
        rst_ni <= 1'b1;
        @(posedge clk_i);

        fetch(32'h0000_1000);  // both halves of a line
        fetch(32'h0000_1004);

        scalar_access_pair: begin
            scalar_start(1'b1, 32'h0000_2004, 4'b0110, 32'hdead_beef);
            scalar_finish();
            scalar_start(1'b0, 32'h0000_2004, 4'hf, '0);
            scalar_finish();
            scalar_start(1'b1, 32'h0000_2000, 4'b1001, 32'h1234_5678);
            scalar_finish();
            scalar_start(1'b0, 32'h0000_2000, 4'hf, '0);
            scalar_finish();
        end

        vector_start(1'b1, 32'h0000_3000, 8'hff, 64'h0123_4567_89ab_cdef);
        vector_finish();
        vector_start(1'b0, 32'h0000_3000, 8'hff, '0);
        vector_finish();
        fetch(32'h0000_3004);

        // vector and scalar in the same cycle, vector goes first
        scalar_start(1'b0, 32'h0000_3000, 4'hf, '0);
        vector_start(1'b1, 32'h0000_3000, 8'h0f, 64'h5555_aaaa_7777_8888);
        wait_for(V_GRANT);
        check("sgnt_o", 64'(sgnt_o), 64'(0));
        vreq_i <= 1'b0;
        wait_for(S_GRANT);
        sreq_i <= 1'b0;
        drain();

        // scalar held behind pending vector traffic
        vpend_store_i <= 1'b1;
        scalar_start(1'b0, 32'h0000_2004, 4'hf, '0);
        expect_no_sgnt(6);
        vpend_store_i <= 1'b0;
        scalar_finish();
        vpend_load_i <= 1'b1;
        scalar_start(1'b0, 32'h0000_2000, 4'hf, '0);
        scalar_finish();
        scalar_start(1'b1, 32'h0000_2000, 4'b0011, 32'hcafe_f00d);
        expect_no_sgnt(6);
        vpend_load_i <= 1'b0;
        scalar_finish();

        fork
            random_fetch(40);
            random_scalar(40);
            random_vector(40);
        join
        drain();

        $display("TB PASSED");
        $finish;
    end

endmodule

// File: hw/vmem_subsys_top.sv
/*
 * memory side of the scalar core and vector unit,
 * data port merge feeding the instruction/data arbiter
 */
`timescale 1ns/10ps
`include "mem_consts.svh"

module vmem_subsys_top import mem_bus_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_ni,

    input  logic               ireq_i,
    output logic               igrant_o,
    input  logic [`ADDR_W-1:0] iaddr_i,
    output logic               irvalid_o,
    output word_rsp_t          irsp_o,

    input  logic               sreq_i,
    output logic               sgnt_o,
    input  word_req_t          sreq_data_i,
    output logic               srvalid_o,
    output word_rsp_t          srsp_o,

    input  logic               vreq_i,
    output logic               vgnt_o,
    input  wide_req_t          vreq_data_i,
    output logic               vrvalid_o,
    output wide_rsp_t          vrsp_o,

    input  logic               vpend_load_i,
    input  logic               vpend_store_i,

    output logic               mem_req_o,
    output wide_req_t          mem_req_data_o,
    input  logic               mem_rvalid_i,
    input  wide_rsp_t          mem_rsp_i
);

    // merged data bus
    logic      dreq, dgnt, drvalid;
    wide_req_t dreq_data;
    wide_rsp_t drsp;

    data_port_merge merge_i (
        .clk_i, .rst_ni,
        .sreq_i, .sgnt_o, .sreq_data_i, .srvalid_o, .srsp_o,
        .vreq_i, .vgnt_o, .vreq_data_i, .vrvalid_o, .vrsp_o,
        .vpend_load_i, .vpend_store_i,
        .dreq_o (dreq), .dgnt_i (dgnt), .dreq_data_o (dreq_data),
        .drvalid_i (drvalid), .drsp_i (drsp)
    );

    mem_port_arbiter arb_i (
        .clk_i, .rst_ni,
        .ireq_i, .igrant_o, .iaddr_i, .irvalid_o, .irsp_o,
        .dreq_i (dreq), .dgnt_o (dgnt), .dreq_data_i (dreq_data),
        .drvalid_o (drvalid), .drsp_o (drsp),
        .mem_req_o, .mem_req_data_o, .mem_rvalid_i, .mem_rsp_i
    );

endmodule

// File: hw/mem_port_arbiter.sv
/*
 * instruction and data arbiter for the memory bus, data first,
 * with an in-order tracker routing the memory responses
 */
`timescale 1ns/10ps
`include "mem_consts.svh"

module mem_port_arbiter import mem_bus_pkg::*, req_track_pkg::*; (
    input  logic               clk_i,
    input  logic               rst_ni,

    input  logic               ireq_i,
    output logic               igrant_o,
    input  logic [`ADDR_W-1:0] iaddr_i,
    output logic               irvalid_o,
    output word_rsp_t          irsp_o,

    input  logic               dreq_i,
    output logic               dgnt_o,
    input  wide_req_t          dreq_data_i,
    output logic               drvalid_o,
    output wide_rsp_t          drsp_o,

    output logic               mem_req_o,
    output wide_req_t          mem_req_data_o,
    input  logic               mem_rvalid_i,
    input  wide_rsp_t          mem_rsp_i
);

    localparam int unsigned NLANES    = `DATA_W / `SDATA_W;
    localparam int unsigned LANE_BITS = $clog2(NLANES);
    localparam int unsigned PTR_W     = $clog2(`TRACK_DEPTH);
    localparam logic [PTR_W:0] DEPTH  = `TRACK_DEPTH;

    track_entry_t         track_q [`TRACK_DEPTH];
    track_entry_t         head, entry;
    logic [PTR_W-1:0]     wr_ptr_q, rd_ptr_q;
    logic [PTR_W:0]       cnt_q;
    logic                 full;
    logic                 push, pop;
    logic [LANE_BITS-1:0] ilane;

    ////////////////////
    // grants

    assign full     = cnt_q == DEPTH;
    assign dgnt_o   = dreq_i & ~full;
    assign igrant_o = ireq_i & ~dreq_i & ~full;

    // only granted requests go out, so the tracker stays in step with memory
    assign mem_req_o = dgnt_o | igrant_o;

    always_comb begin
        mem_req_data_o = dreq_data_i;
        if (!dreq_i) begin
            mem_req_data_o.addr  = iaddr_i;
            mem_req_data_o.we    = 1'b0;
            mem_req_data_o.be    = '1;
            mem_req_data_o.wdata = '0;
        end
    end

    ////////////////////
    // tracker

    assign push = mem_req_o;
    assign pop  = mem_rvalid_i;

    always_comb begin
        entry.src   = dreq_i ? SRC_DATA : SRC_INSTR;
        entry.write = dreq_i & dreq_data_i.we;
        entry.addr  = mem_req_data_o.addr;
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            cnt_q    <= '0;
        end else begin
            if (push) wr_ptr_q <= wr_ptr_q + 1'b1;
            if (pop)  rd_ptr_q <= rd_ptr_q + 1'b1;
            cnt_q <= cnt_q + (PTR_W+1)'(push) - (PTR_W+1)'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) track_q[wr_ptr_q] <= entry;
    end

    assign head  = track_q[rd_ptr_q];
    assign ilane = head.addr[LANE_BITS+1:2];

    assign irvalid_o    = pop & (head.src == SRC_INSTR);
    assign irsp_o.rdata = mem_rsp_i.rdata[ilane*`SDATA_W +: `SDATA_W];
    assign irsp_o.err   = mem_rsp_i.err;

    assign drvalid_o    = pop & (head.src == SRC_DATA);
    assign drsp_o.rdata = head.write ? '0 : mem_rsp_i.rdata;  // writes return no data
    assign drsp_o.err   = mem_rsp_i.err;

    a_rvalid_tracked: assert property (@(posedge clk_i) disable iff (!rst_ni)
        mem_rvalid_i |-> cnt_q != '0)
        else $error("memory response with empty tracker");

endmodule

// File: hw/data_port_merge.sv
/*
 * scalar and vector data ports merged onto one wide data bus,
 * vector first, with an in-order record routing the responses
 */
`timescale 1ns/10ps
`include "mem_consts.svh"

module data_port_merge import mem_bus_pkg::*, req_track_pkg::*; (
    input  logic      clk_i,
    input  logic      rst_ni,

    input  logic      sreq_i,
    output logic      sgnt_o,
    input  word_req_t sreq_data_i,
    output logic      srvalid_o,
    output word_rsp_t srsp_o,

    input  logic      vreq_i,
    output logic      vgnt_o,
    input  wide_req_t vreq_data_i,
    output logic      vrvalid_o,
    output wide_rsp_t vrsp_o,

    input  logic      vpend_load_i,
    input  logic      vpend_store_i,

    output logic      dreq_o,
    input  logic      dgnt_i,
    output wide_req_t dreq_data_o,
    input  logic      drvalid_i,
    input  wide_rsp_t drsp_i
);

    localparam int unsigned NLANES    = `DATA_W / `SDATA_W;
    localparam int unsigned LANE_BITS = $clog2(NLANES);
    localparam int unsigned SBYTES    = `SDATA_W / 8;

    typedef struct packed {
        data_src_e            src;
        logic [LANE_BITS-1:0] lane;
    } rec_t;

    logic                 shold;
    logic [LANE_BITS-1:0] slane;
    logic                 push, pop;
    rec_t                 rec_q [2];
    rec_t                 head;
    logic                 wr_ptr_q, rd_ptr_q;
    logic [1:0]           cnt_q;

    // scalar waits for the vector unit to drain hazards
    assign shold = vreq_i | vpend_store_i | (vpend_load_i & sreq_data_i.we);
    assign slane = sreq_data_i.addr[LANE_BITS+1:2];

    assign dreq_o = vreq_i | (sreq_i & ~shold);
    assign vgnt_o = dgnt_i & vreq_i;
    assign sgnt_o = dgnt_i & sreq_i & ~shold;

    always_comb begin
        dreq_data_o       = '0;
        dreq_data_o.addr  = sreq_data_i.addr;
        dreq_data_o.we    = sreq_data_i.we;
        dreq_data_o.be[slane*SBYTES +: SBYTES] = sreq_data_i.be;  // into its lane
        for (int i = 0; i < NLANES; i++) begin
            dreq_data_o.wdata[i*`SDATA_W +: `SDATA_W] = sreq_data_i.wdata;
        end
        if (vreq_i) begin
            dreq_data_o = vreq_data_i;
        end
    end

    ////////////////////
    // response record

    assign push = vgnt_o | sgnt_o;
    assign pop  = drvalid_i;
    assign head = rec_q[rd_ptr_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= 1'b0;
            rd_ptr_q <= 1'b0;
            cnt_q    <= '0;
        end else begin
            if (push) wr_ptr_q <= ~wr_ptr_q;
            if (pop)  rd_ptr_q <= ~rd_ptr_q;
            cnt_q <= cnt_q + 2'(push) - 2'(pop);
        end
    end

    always_ff @(posedge clk_i) begin
        if (push) begin
            rec_q[wr_ptr_q] <= '{src: vreq_i ? DSRC_VECTOR : DSRC_SCALAR, lane: slane};
        end
    end

    assign srvalid_o    = drvalid_i & (head.src == DSRC_SCALAR);
    assign vrvalid_o    = drvalid_i & (head.src == DSRC_VECTOR);
    assign srsp_o.rdata = drsp_i.rdata[head.lane*`SDATA_W +: `SDATA_W];
    assign srsp_o.err   = drsp_i.err;
    assign vrsp_o       = drsp_i;

    a_rec_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        (push && !pop) |-> cnt_q != 2'd2)
        else $error("data response record overflow");

    a_rec_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
        pop |-> cnt_q != 2'd0)
        else $error("data response without a recorded request");

endmodule

// File: hw/req_track_pkg.sv
/*
 * requester identities and the tracked memory request entry
 */
`include "mem_consts.svh"

package req_track_pkg;

    typedef enum logic {
        SRC_INSTR = 1'b0,
        SRC_DATA  = 1'b1
    } mem_src_e;

    typedef enum logic {
        DSRC_SCALAR = 1'b0,
        DSRC_VECTOR = 1'b1
    } data_src_e;

    typedef struct packed {
        mem_src_e           src;
        logic               write;
        logic [`ADDR_W-1:0] addr;  // for instruction lane select
    } track_entry_t;

endpackage

// File: hw/mem_bus_pkg.sv
/*
 * request and response structs for the word and wide memory buses
 */
`include "mem_consts.svh"

package mem_bus_pkg;

    // scalar data or instruction fetch request
    typedef struct packed {
        logic [`ADDR_W-1:0]    addr;
        logic                  we;
        logic [`SDATA_W/8-1:0] be;
        logic [`SDATA_W-1:0]   wdata;
    } word_req_t;

    // full width request, vector port and memory bus
    typedef struct packed {
        logic [`ADDR_W-1:0]   addr;
        logic                 we;
        logic [`DATA_W/8-1:0] be;
        logic [`DATA_W-1:0]   wdata;
    } wide_req_t;

    typedef struct packed {
        logic [`SDATA_W-1:0] rdata;
        logic                err;
    } word_rsp_t;

    typedef struct packed {
        logic [`DATA_W-1:0] rdata;
        logic               err;
    } wide_rsp_t;

endpackage

// File: hw/mem_consts.svh
/*
 * bus widths and tracker depth of the memory subsystem
 */
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// address width of all ports
`define ADDR_W 32

// memory bus and vector port width in bits
`define DATA_W 64

// scalar and instruction word width
`define SDATA_W 32

// outstanding memory requests tracked by the arbiter
`define TRACK_DEPTH 32

`endif
